// ==== FetchTypes.sv ====
// Fetch path shared definitions
// Widths, memory and buffer sizes, reset PC and the fetch controller states

package FetchTypes;

    // Address and data widths
    localparam int XLEN = 32;
    localparam int LineWidth = 64;
    localparam int InsnWidth = 32;
    localparam int HalfWidth = 16;
    localparam int InsnsPerLine = LineWidth / InsnWidth;

    // Byte offsets within a word and within a line
    localparam int WordOffsetWidth = $clog2(InsnWidth / 8);
    localparam int LineOffsetWidth = $clog2(LineWidth / 8);
    localparam int InsnIndexWidth = $clog2(InsnsPerLine);

    // Line memory size, fault bound is MemLines x 8 bytes
    localparam int MemLines = 16;
    localparam int MemIndexWidth = $clog2(MemLines);

    // Halfword instruction buffer
    localparam int BufferDepth = 8;
    localparam int BufferPtrWidth = $clog2(BufferDepth);
    localparam int BufferCountWidth = $clog2(BufferDepth + 1);

    // Interrupt tag carried with each entry
    localparam int IntCodeWidth = 4;

    // First fetch address after reset
    localparam logic [XLEN-1:0] ResetPc = '0;

    // Fetch controller states
    // Idle lasts one cycle after reset, no request issued
    typedef enum logic [1:0] {
        FetchIdle,
        FetchRun,
        FetchStall
    } FetchState;

endpackage

// ==== FetchPcGen.sv ====
// Fetch PC generator
// Holds the fetch PC, issues one word request per cycle, holds under stall
// and restarts at the redirect PC

`timescale 1ns/100ps

module FetchPcGen import FetchTypes::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic redirectValid,
    input  logic [XLEN-1:0] redirectPc,
    output logic reqValid,
    output logic [XLEN-1:0] reqPc,
    output FetchState state
);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] seqPc;
    FetchState nextState;

    always_comb begin
        // Clear bit 1 so a compressed-aligned start realigns to the next word
        seqPc = (pc & ~XLEN'(2)) + XLEN'(InsnWidth / 8);
        // No request during the idle cycle after reset
        reqValid = state != FetchIdle;
        reqPc = pc;
    end

    always_comb begin
        case (state)
            FetchIdle: nextState = FetchRun;
            default: nextState = stall ? FetchStall : FetchRun;
        endcase
        // Redirect wins over stall
        if (redirectValid) begin
            nextState = FetchRun;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ResetPc;
            state <= FetchIdle;
        end else begin
            state <= nextState;
            if (redirectValid) begin
                pc <= redirectPc;
            end else if (reqValid && !stall) begin
                // Request taken by the memory, move on
                pc <= seqPc;
            end
        end
    end
endmodule

// ==== LineMemory.sv ====
// Line memory standing in for the instruction cache read stage
// Always hits, returns the 64-bit line one cycle after the request
// Addresses past the loaded lines return a fault with a zero line

`timescale 1ns/100ps

module LineMemory import FetchTypes::*; (
    input  logic clk,
    input  logic rst,
    input  logic hold,
    input  logic flush,
    input  logic reqValid,
    input  logic [XLEN-1:0] reqPc,
    input  logic loadEnable,
    input  logic [MemIndexWidth-1:0] loadIndex,
    input  logic [LineWidth-1:0] loadLine,
    output logic respValid,
    output logic [XLEN-1:0] respPc,
    output logic [LineWidth-1:0] respLine,
    output logic respFault
);
    logic [LineWidth-1:0] lines [MemLines];

    logic [MemIndexWidth-1:0] readIndex;
    logic readFault;
    logic [LineWidth-1:0] readLine;

    always_comb begin
        readIndex = reqPc[LineOffsetWidth +: MemIndexWidth];
        // Any address bit above the index means past MemLines x 8 bytes
        readFault = reqPc[XLEN-1:LineOffsetWidth+MemIndexWidth] != '0;
        readLine = readFault ? '0 : lines[readIndex];
    end

    // Load port used by the testbench
    always_ff @(posedge clk) begin
        if (loadEnable) begin
            lines[loadIndex] <= loadLine;
        end
    end

    // Valid bit of the read stage
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            respValid <= 1'b0;
        end else if (!hold) begin
            respValid <= reqValid;
        end
    end

    // Response payload, frozen while the traverse stage stalls
    always_ff @(posedge clk) begin
        if (!hold) begin
            respPc <= reqPc;
            respLine <= readLine;
            respFault <= readFault;
        end
    end
endmodule

// ==== InsnTraverseStage.sv ====
// Instruction traverse stage
// Picks the word at the PC out of the line and splits it into a low and a
// high halfword entry for the buffer, stalls when buffer space is short

`timescale 1ns/100ps

module InsnTraverseStage import FetchTypes::*; (
    input  logic respValid,
    input  logic [XLEN-1:0] respPc,
    input  logic [LineWidth-1:0] respLine,
    input  logic respFault,
    input  logic [BufferCountWidth-1:0] writableCount,
    input  logic interruptValid,
    input  logic [IntCodeWidth-1:0] interruptCode,
    output logic stall,
    output logic writeLow,
    output logic writeHigh,
    output logic [XLEN-1:0] lowPc,
    output logic [HalfWidth-1:0] lowHalf,
    output logic lowFault,
    output logic lowIntValid,
    output logic [IntCodeWidth-1:0] lowIntCode,
    output logic [XLEN-1:0] highPc,
    output logic [HalfWidth-1:0] highHalf,
    output logic highFault,
    output logic highIntValid,
    output logic [IntCodeWidth-1:0] highIntCode
);
    logic compressedStart;
    logic [InsnIndexWidth-1:0] wordIndex;
    logic [InsnsPerLine-1:0][InsnWidth-1:0] words;
    logic [InsnWidth-1:0] word;

    always_comb begin
        // PC bit 1 set, only the upper halfword belongs to this fetch
        compressedStart = respPc[1];
        wordIndex = respPc[WordOffsetWidth +: InsnIndexWidth];
        words = respLine;
        word = words[wordIndex];
        // Both halves need room, so ask for two free entries
        stall = writableCount < BufferCountWidth'(2);
    end

    always_comb begin
        writeLow = respValid && !stall && !compressedStart;
        writeHigh = respValid && !stall;

        lowPc = respPc;
        lowHalf = word[HalfWidth-1:0];
        lowFault = respFault;
        lowIntValid = interruptValid;
        lowIntCode = interruptCode;

        // High entry keeps the fetch PC on a compressed start
        highPc = compressedStart ? respPc : respPc + XLEN'(2);
        highHalf = word[InsnWidth-1:HalfWidth];
        highFault = respFault;
        highIntValid = interruptValid;
        highIntCode = interruptCode;
    end
endmodule

// ==== InsnBuffer.sv ====
// Halfword instruction buffer
// Circular FIFO, up to two writes per cycle (low first) and one
// valid/ready read, reports its free entry count to the traverse stage

`timescale 1ns/100ps

module InsnBuffer import FetchTypes::*; (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic writeLow,
    input  logic writeHigh,
    input  logic [XLEN-1:0] lowPc,
    input  logic [HalfWidth-1:0] lowHalf,
    input  logic lowFault,
    input  logic lowIntValid,
    input  logic [IntCodeWidth-1:0] lowIntCode,
    input  logic [XLEN-1:0] highPc,
    input  logic [HalfWidth-1:0] highHalf,
    input  logic highFault,
    input  logic highIntValid,
    input  logic [IntCodeWidth-1:0] highIntCode,
    input  logic outReady,
    output logic [BufferCountWidth-1:0] writableCount,
    output logic outValid,
    output logic [XLEN-1:0] outPc,
    output logic [HalfWidth-1:0] outHalf,
    output logic outFault,
    output logic outIntValid,
    output logic [IntCodeWidth-1:0] outIntCode
);
    // Entry storage, one array per field
    logic [XLEN-1:0] pcMem [BufferDepth];
    logic [HalfWidth-1:0] halfMem [BufferDepth];
    logic faultMem [BufferDepth];
    logic intValidMem [BufferDepth];
    logic [IntCodeWidth-1:0] intCodeMem [BufferDepth];

    logic [BufferPtrWidth-1:0] writePtr;
    logic [BufferPtrWidth-1:0] highPtr;
    logic [BufferPtrWidth-1:0] readPtr;
    logic [BufferCountWidth-1:0] count;
    logic [1:0] writeNum;
    logic pop;

    always_comb begin
        // High entry lands right after the low one when both are written
        highPtr = writeLow ? writePtr + 1'b1 : writePtr;
        writeNum = {1'b0, writeLow} + {1'b0, writeHigh};
        outValid = count != '0;
        pop = outValid && outReady;
        // From the count register only, same-cycle reads are not counted
        writableCount = BufferCountWidth'(BufferDepth) - count;
        outPc = pcMem[readPtr];
        outHalf = halfMem[readPtr];
        outFault = faultMem[readPtr];
        outIntValid = intValidMem[readPtr];
        outIntCode = intCodeMem[readPtr];
    end

    always_ff @(posedge clk) begin
        if (writeLow) begin
            pcMem[writePtr] <= lowPc;
            halfMem[writePtr] <= lowHalf;
            faultMem[writePtr] <= lowFault;
            intValidMem[writePtr] <= lowIntValid;
            intCodeMem[writePtr] <= lowIntCode;
        end
        if (writeHigh) begin
            pcMem[highPtr] <= highPc;
            halfMem[highPtr] <= highHalf;
            faultMem[highPtr] <= highFault;
            intValidMem[highPtr] <= highIntValid;
            intCodeMem[highPtr] <= highIntCode;
        end
    end

    // Pointers and occupancy, a flush empties the buffer
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
        end else begin
            writePtr <= writePtr + BufferPtrWidth'(writeNum);
            readPtr <= readPtr + BufferPtrWidth'(pop);
            count <= count + BufferCountWidth'(writeNum) - BufferCountWidth'(pop);
        end
    end
endmodule

// ==== FetchUnit.sv ====
// Fetch unit top level
// PC generator, line memory, traverse stage and halfword buffer in a row
// Redirect flushes the memory response and the buffer

`timescale 1ns/100ps

module FetchUnit import FetchTypes::*; (
    input  logic clk,
    input  logic rst,
    input  logic redirectValid,
    input  logic [XLEN-1:0] redirectPc,
    input  logic interruptValid,
    input  logic [IntCodeWidth-1:0] interruptCode,
    input  logic loadEnable,
    input  logic [MemIndexWidth-1:0] loadIndex,
    input  logic [LineWidth-1:0] loadLine,
    input  logic outReady,
    output logic outValid,
    output logic [XLEN-1:0] outPc,
    output logic [HalfWidth-1:0] outHalf,
    output logic outFault,
    output logic outIntValid,
    output logic [IntCodeWidth-1:0] outIntCode,
    output FetchState fetchState
);
    // Request side
    logic stall;
    logic reqValid;
    logic [XLEN-1:0] reqPc;

    // Memory response
    logic respValid;
    logic [XLEN-1:0] respPc;
    logic [LineWidth-1:0] respLine;
    logic respFault;

    // Buffer write side
    logic [BufferCountWidth-1:0] writableCount;
    logic writeLow;
    logic writeHigh;
    logic [XLEN-1:0] lowPc;
    logic [HalfWidth-1:0] lowHalf;
    logic lowFault;
    logic lowIntValid;
    logic [IntCodeWidth-1:0] lowIntCode;
    logic [XLEN-1:0] highPc;
    logic [HalfWidth-1:0] highHalf;
    logic highFault;
    logic highIntValid;
    logic [IntCodeWidth-1:0] highIntCode;

    FetchPcGen pcGen (
        .clk(clk), .rst(rst), .stall(stall),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .reqValid(reqValid), .reqPc(reqPc), .state(fetchState)
    );

    // The stall doubles as the memory hold
    LineMemory lineMemory (
        .clk(clk), .rst(rst), .hold(stall), .flush(redirectValid),
        .reqValid(reqValid), .reqPc(reqPc),
        .loadEnable(loadEnable), .loadIndex(loadIndex), .loadLine(loadLine),
        .respValid(respValid), .respPc(respPc), .respLine(respLine),
        .respFault(respFault)
    );

    InsnTraverseStage traverseStage (
        .respValid(respValid), .respPc(respPc), .respLine(respLine),
        .respFault(respFault), .writableCount(writableCount),
        .interruptValid(interruptValid), .interruptCode(interruptCode),
        .stall(stall), .writeLow(writeLow), .writeHigh(writeHigh),
        .lowPc(lowPc), .lowHalf(lowHalf), .lowFault(lowFault),
        .lowIntValid(lowIntValid), .lowIntCode(lowIntCode),
        .highPc(highPc), .highHalf(highHalf), .highFault(highFault),
        .highIntValid(highIntValid), .highIntCode(highIntCode)
    );

    InsnBuffer insnBuffer (
        .clk(clk), .rst(rst), .flush(redirectValid),
        .writeLow(writeLow), .writeHigh(writeHigh),
        .lowPc(lowPc), .lowHalf(lowHalf), .lowFault(lowFault),
        .lowIntValid(lowIntValid), .lowIntCode(lowIntCode),
        .highPc(highPc), .highHalf(highHalf), .highFault(highFault),
        .highIntValid(highIntValid), .highIntCode(highIntCode),
        .outReady(outReady), .writableCount(writableCount),
        .outValid(outValid), .outPc(outPc), .outHalf(outHalf),
        .outFault(outFault), .outIntValid(outIntValid), .outIntCode(outIntCode)
    );
endmodule

// ==== FetchUnitTb.sv ====
// Fetch unit testbench
// Loads the line memory from the golden file, runs each phase after a redirect
// and checks the halfword stream against the expected records

`timescale 1ns/100ps

module FetchUnitTb import FetchTypes::*; ();
    localparam int DriveDelay = 10;
    localparam int FillCycles = 12;
    localparam logic [31:0] RandomSeed = 32'he1f4d18a;

    // DUT ports
    logic clk = 1'b0;
    logic rst;
    logic redirectValid;
    logic [XLEN-1:0] redirectPc;
    logic interruptValid;
    logic [IntCodeWidth-1:0] interruptCode;
    logic loadEnable;
    logic [MemIndexWidth-1:0] loadIndex;
    logic [LineWidth-1:0] loadLine;
    logic outReady;
    logic outValid;
    logic [XLEN-1:0] outPc;
    logic [HalfWidth-1:0] outHalf;
    logic outFault;
    logic outIntValid;
    logic [IntCodeWidth-1:0] outIntCode;
    FetchState fetchState;

    // Golden file contents
    logic [MemIndexWidth-1:0] lineIndex [$];
    logic [LineWidth-1:0] lineData [$];
    string phaseName [$];
    logic [XLEN-1:0] phasePc [$];
    logic phaseIntValid [$];
    logic [IntCodeWidth-1:0] phaseIntCode [$];
    int phaseMode [$];
    int phaseCount [$];
    logic [XLEN-1:0] expPc [$];
    logic [HalfWidth-1:0] expHalf [$];
    logic expFault [$];
    logic expIntValid [$];
    logic [IntCodeWidth-1:0] expIntCode [$];

    int errors = 0;
    int recordIndex = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    logic [31:0] randState;

    FetchUnit dut (
        .clk(clk), .rst(rst), .redirectValid(redirectValid), .redirectPc(redirectPc),
        .interruptValid(interruptValid), .interruptCode(interruptCode),
        .loadEnable(loadEnable), .loadIndex(loadIndex), .loadLine(loadLine),
        .outReady(outReady), .outValid(outValid), .outPc(outPc), .outHalf(outHalf),
        .outFault(outFault), .outIntValid(outIntValid), .outIntCode(outIntCode),
        .fetchState(fetchState)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // Run limit from the number of expected records
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("Timeout: expected records still missing after %0d cycles", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Inputs change a short delay after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic readGolden();
        int fd;
        int code;
        string tag;
        string name;
        logic [8*128-1:0] rest;
        logic [XLEN-1:0] pc;
        logic [LineWidth-1:0] data;
        logic [HalfWidth-1:0] half;
        logic [MemIndexWidth-1:0] index;
        logic fault;
        logic intValid;
        logic [IntCodeWidth-1:0] intCode;
        int mode;
        int count;
        int total;
        fd = $fopen("fetchGolden.txt", "r");
        total = 0;
        if (fd == 0) begin
            $display("Could not open the golden file fetchGolden.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %s", tag);
                if (code == 1) begin
                    case (tag)
                        "#": code = $fgets(rest, fd);
                        "L": begin
                            code = $fscanf(fd, " %h %h", index, data);
                            lineIndex.push_back(index);
                            lineData.push_back(data);
                        end
                        "P": begin
                            code = $fscanf(fd, " %s %h %h %h %d %d", name, pc, intValid,
                                           intCode, mode, count);
                            phaseName.push_back(name);
                            phasePc.push_back(pc);
                            phaseIntValid.push_back(intValid);
                            phaseIntCode.push_back(intCode);
                            phaseMode.push_back(mode);
                            phaseCount.push_back(count);
                            total += count;
                        end
                        "E": begin
                            code = $fscanf(fd, " %h %h %h %h %h", pc, half, fault, intValid,
                                           intCode);
                            expPc.push_back(pc);
                            expHalf.push_back(half);
                            expFault.push_back(fault);
                            expIntValid.push_back(intValid);
                            expIntCode.push_back(intCode);
                        end
                        default: begin
                            $display("Golden file holds an unknown record tag %s", tag);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        // Phase counts must cover the expected records exactly
        if (total != expPc.size()) begin
            $display("Golden file phases ask for %0d records but %0d are listed",
                     total, expPc.size());
            errors++;
        end
    endtask

    task automatic compareField(input string phase, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s record %0d %s: expected %h actual %h", phase, recordIndex,
                     field, expected, actual);
            errors++;
        end
    endtask

    task automatic checkRecord(input int p);
        compareField(phaseName[p], "pc", expPc[recordIndex], outPc);
        compareField(phaseName[p], "half", 32'(expHalf[recordIndex]), 32'(outHalf));
        compareField(phaseName[p], "fault", 32'(expFault[recordIndex]), 32'(outFault));
        compareField(phaseName[p], "intValid", 32'(expIntValid[recordIndex]),
                     32'(outIntValid));
        compareField(phaseName[p], "intCode", 32'(expIntCode[recordIndex]),
                     32'(outIntCode));
        recordIndex++;
    endtask

    // Ready mode 0 always high, 1 random, 2 fill the buffer before the redirect
    task automatic runPhase(input int p);
        int taken;
        int errorsBefore;
        int waited;
        taken = 0;
        errorsBefore = errors;
        waited = 0;
        if (phaseMode[p] == 2) begin
            // Hold ready low until the full buffer stalls the fetch
            outReady = 1'b0;
            @(negedge clk);
            while (fetchState !== FetchStall && waited < FillCycles) begin
                nextCycle();
                @(negedge clk);
                waited++;
            end
            if (fetchState !== FetchStall) begin
                $display("%s: fetch did not stall on a full buffer before the redirect",
                         phaseName[p]);
                errors++;
            end
            nextCycle();
        end
        redirectValid = 1'b1;
        redirectPc = phasePc[p];
        interruptValid = phaseIntValid[p];
        interruptCode = phaseIntCode[p];
        nextCycle();
        redirectValid = 1'b0;
        while (taken < phaseCount[p]) begin
            if (phaseMode[p] == 1) begin
                randState = xorshift(randState);
                outReady = randState[0];
            end else begin
                outReady = 1'b1;
            end
            // Mid-cycle sample of a handshake that transfers on the next edge
            @(negedge clk);
            if (outValid && outReady) begin
                checkRecord(p);
                taken++;
            end
            nextCycle();
        end
        $display("Phase %s: %0d records, %0d errors", phaseName[p], taken,
                 errors - errorsBefore);
    endtask

    initial begin
        rst = 1'b1;
        redirectValid = 1'b0;
        redirectPc = '0;
        interruptValid = 1'b0;
        interruptCode = '0;
        loadEnable = 1'b0;
        loadIndex = '0;
        loadLine = '0;
        outReady = 1'b1;
        randState = RandomSeed;
        readGolden();
        cycleLimit = 20 * expPc.size() + 100;

        // Memory load overlaps the two reset cycles
        for (int i = 0; i < lineData.size() || i < 2; i++) begin
            nextCycle();
            loadEnable = i < lineData.size();
            if (i < lineData.size()) begin
                loadIndex = lineIndex[i];
                loadLine = lineData[i];
            end
            if (i == 1) begin
                rst = 1'b0;
                @(negedge clk);
                if (outValid !== 1'b0 || fetchState !== FetchIdle) begin
                    $display("Fetch unit not idle with an empty buffer after reset");
                    errors++;
                end
            end
        end
        nextCycle();
        loadEnable = 1'b0;

        for (int p = 0; p < phaseName.size(); p++) begin
            runPhase(p);
        end

        $display("Done: %0d phases, %0d records checked, %0d errors", phaseName.size(),
                 recordIndex, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule

// ==== fetchGolden.txt ====
# L index line | P name redirectPc intValid intCode readyMode(0 high 1 random 2 fill) count
# E pc half fault intValid intCode, listed after their phase in stream order
L 0 C006C004C002C000
L 1 C00EC00CC00AC008
L 2 C016C014C012C010
L 3 C01EC01CC01AC018
L f C07EC07CC07AC078
P resetStream 00000000 0 0 0 6
E 00000000 C000 0 0 0
E 00000002 C002 0 0 0
E 00000004 C004 0 0 0
E 00000006 C006 0 0 0
E 00000008 C008 0 0 0
E 0000000a C00A 0 0 0
P compressed 0000000a 0 0 0 3
E 0000000a C00A 0 0 0
E 0000000c C00C 0 0 0
E 0000000e C00E 0 0 0
P randomReady 00000000 0 0 1 10
E 00000000 C000 0 0 0
E 00000002 C002 0 0 0
E 00000004 C004 0 0 0
E 00000006 C006 0 0 0
E 00000008 C008 0 0 0
E 0000000a C00A 0 0 0
E 0000000c C00C 0 0 0
E 0000000e C00E 0 0 0
E 00000010 C010 0 0 0
E 00000012 C012 0 0 0
P faultBound 0000007c 0 0 0 4
E 0000007c C07C 0 0 0
E 0000007e C07E 0 0 0
E 00000080 0000 1 0 0
E 00000082 0000 1 0 0
P interrupt 00000010 1 9 0 3
E 00000010 C010 0 1 9
E 00000012 C012 0 1 9
E 00000014 C014 0 1 9
P flushFull 00000018 0 0 2 2
E 00000018 C018 0 0 0
E 0000001a C01A 0 0 0

// ==== project.f ====
FetchTypes.sv
FetchPcGen.sv
LineMemory.sv
InsnTraverseStage.sv
InsnBuffer.sv
FetchUnit.sv
FetchUnitTb.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - FetchTypes.sv
  - FetchPcGen.sv
  - LineMemory.sv
  - InsnTraverseStage.sv
  - InsnBuffer.sv
  - FetchUnit.sv
  - target: test
    files:
      - FetchUnitTb.sv
